//--- hdl/agc_regs.sv
`timescale 1ns/1ps

module agc_regs import trigger_pkg::*; (
    input  logic                      aclk,
    input  logic                      rst_i,
    // wishbone target, cyc already decoded for this channel
    input  logic                      cyc_i,
    input  logic                      stb_i,
    input  logic                      we_i,
    input  logic [REG_ADR_BITS-1:0]   adr_i,
    input  logic [WB_DAT_BITS-1:0]    dat_i,
    // clipped lanes in the word now leaving the scaler
    input  logic [CLIP_ADD_BITS-1:0]  clip_add_i,
    output logic                      ack_o,
    output logic                      err_o,
    output logic [WB_DAT_BITS-1:0]    dat_o,
    // settings to the scaler
    output logic [GAIN_BITS-1:0]      gain_o,
    output logic signed [IN_BITS-1:0] offset_o
);

    // new request seen this cycle
    logic req;
    // offset maps to a register
    logic hit;
    // accepted write
    logic wr;
    // software clear of the clip counter
    logic clip_clr;
    // one extra bit to catch counter overflow
    logic [CLIP_BITS:0] clip_sum;
    logic [CLIP_BITS-1:0] clip_cnt;
    // read value for the current offset
    logic [WB_DAT_BITS-1:0] rd_dat;

    // no new request while answering
    // master still holds cyc/stb during the answer cycle
    assign req = cyc_i && stb_i && !ack_o && !err_o;
    assign wr = req && we_i && hit;
    assign clip_clr = wr && (adr_i == REG_CLIP);

    // register decode and read mux
    always_comb begin
        hit = 1'b1;
        rd_dat = '0;
        case (adr_i)
            // gain zero-extended
            REG_GAIN:   rd_dat = WB_DAT_BITS'(gain_o);
            // offset is signed, cast keeps the sign
            REG_OFFSET: rd_dat = WB_DAT_BITS'(offset_o);
            REG_CLIP:   rd_dat = WB_DAT_BITS'(clip_cnt);
            // unmapped offset, answer with err
            default:    hit = 1'b0;
        endcase
    end

    // handshake and settings registers
    always_ff @(posedge aclk) begin
        if (rst_i) begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
            gain_o <= GAIN_RESET;
            offset_o <= '0;
        end else begin
            // answer one cycle after the request
            ack_o <= req && hit;
            err_o <= req && !hit;
            // write data lands on the request edge, in use from the ack cycle
            if (wr && (adr_i == REG_GAIN)) begin
                gain_o <= dat_i[GAIN_BITS-1:0];
            end
            if (wr && (adr_i == REG_OFFSET)) begin
                offset_o <= dat_i[IN_BITS-1:0];
            end
        end
    end

    // read data captured with the request, valid with ack
    // clip value here covers words out of the scaler up to the previous cycle
    always_ff @(posedge aclk) begin
        if (req) begin
            dat_o <= rd_dat;
        end
    end

    // clip counter, saturating
    assign clip_sum = {1'b0, clip_cnt} + (CLIP_BITS + 1)'(clip_add_i);

    always_ff @(posedge aclk) begin
        // clear wins over the increment
        if (rst_i || clip_clr) begin
            clip_cnt <= '0;
        end else if (clip_sum[CLIP_BITS]) begin
            clip_cnt <= '1;
        end else begin
            clip_cnt <= clip_sum[CLIP_BITS-1:0];
        end
    end

endmodule

//--- hdl/agc_scale.sv
`timescale 1ns/1ps

module agc_scale import trigger_pkg::*; (
    input  logic                           aclk,
    input  logic                           rst_i,
    // eight signed samples per clock
    input  logic [LANES-1:0][IN_BITS-1:0]  dat_i,
    input  logic [GAIN_BITS-1:0]           gain_i,
    input  logic signed [IN_BITS-1:0]      offset_i,
    // eight saturated samples, two cycles after dat_i
    output logic [LANES-1:0][OUT_BITS-1:0] dat_o,
    // clipped lanes in the word at dat_o
    output logic [CLIP_ADD_BITS-1:0]       clip_add_o
);

    // stage 1 registers
    logic signed [DIFF_BITS-1:0] diff_q [LANES];
    // gain travels with its word so both settings come from the same cycle
    logic [GAIN_BITS-1:0] gain_q;
    // gain as a positive signed operand
    logic signed [PROD_BITS-1:0] gain_ext;

    // stage 2 combinational path
    logic signed [PROD_BITS-1:0] prod [LANES];
    logic signed [SCALED_BITS-1:0] scaled [LANES];
    logic [LANES-1:0][OUT_BITS-1:0] lane_sat;
    logic [LANES-1:0] lane_clip;
    logic [CLIP_ADD_BITS-1:0] clip_sum;

    // stage 1: remove the offset
    // 13 bits hold any 12-bit sample minus any 12-bit offset
    always_ff @(posedge aclk) begin
        for (int i = 0; i < LANES; i++) begin
            diff_q[i] <= DIFF_BITS'($signed(dat_i[i])) - DIFF_BITS'(offset_i);
        end
        gain_q <= gain_i;
    end

    assign gain_ext = $signed({{(PROD_BITS - GAIN_BITS){1'b0}}, gain_q});

    // stage 2: multiply per lane
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        assign prod[g] = PROD_BITS'(diff_q[g]) * gain_ext;
        // dropping the fraction bits is an arithmetic shift
        // rounds toward minus infinity
        assign scaled[g] = prod[g][PROD_BITS-1:GAIN_FRAC_BITS];
    end

    // clamp to -16..15 and count the lanes that were clamped
    always_comb begin
        clip_sum = '0;
        for (int i = 0; i < LANES; i++) begin
            if (scaled[i] > SCALED_BITS'(OUT_MAX)) begin
                lane_sat[i] = OUT_MAX;
                lane_clip[i] = 1'b1;
            end else if (scaled[i] < SCALED_BITS'(OUT_MIN)) begin
                lane_sat[i] = OUT_MIN;
                lane_clip[i] = 1'b1;
            end else begin
                // in range, low bits are the value
                lane_sat[i] = scaled[i][OUT_BITS-1:0];
                lane_clip[i] = 1'b0;
            end
            clip_sum = clip_sum + CLIP_ADD_BITS'(lane_clip[i]);
        end
    end

    // stage 2 registers, tally aligned with its word
    always_ff @(posedge aclk) begin
        if (rst_i) begin
            dat_o <= '0;
            clip_add_o <= '0;
        end else begin
            dat_o <= lane_sat;
            clip_add_o <= clip_sum;
        end
    end

endmodule

//--- hdl/trigger_chain.sv
`timescale 1ns/1ps

module trigger_chain import trigger_pkg::*; (
    input  logic                      aclk,
    input  logic                      rst_i,
    // per-channel register bus
    input  logic                      wb_cyc_i,
    input  logic                      wb_stb_i,
    input  logic                      wb_we_i,
    input  logic [REG_ADR_BITS-1:0]   wb_adr_i,
    input  logic [WB_DAT_BITS-1:0]    wb_dat_i,
    output logic                      wb_ack_o,
    output logic                      wb_err_o,
    output logic [WB_DAT_BITS-1:0]    wb_dat_o,
    // sample stream, 96 bits in and 40 bits out
    input  logic [CHAN_IN_BITS-1:0]   dat_i,
    output logic [CHAN_OUT_BITS-1:0]  dat_o
);

    // settings from the registers
    logic [GAIN_BITS-1:0] gain;
    logic signed [IN_BITS-1:0] offset;
    // clip tally back to the counter
    logic [CLIP_ADD_BITS-1:0] clip_add;
    // lane views of the stream words
    logic [LANES-1:0][IN_BITS-1:0] lane_in;
    logic [LANES-1:0][OUT_BITS-1:0] lane_out;

    // lane i sits at bit 12*i in, 5*i out
    for (genvar l = 0; l < LANES; l++) begin : g_lane_map
        assign lane_in[l] = dat_i[IN_BITS*l +: IN_BITS];
        assign dat_o[OUT_BITS*l +: OUT_BITS] = lane_out[l];
    end

    agc_regs i_agc_regs (
        .aclk       (aclk),
        .rst_i      (rst_i),
        .cyc_i      (wb_cyc_i),
        .stb_i      (wb_stb_i),
        .we_i       (wb_we_i),
        .adr_i      (wb_adr_i),
        .dat_i      (wb_dat_i),
        .clip_add_i (clip_add),
        .ack_o      (wb_ack_o),
        .err_o      (wb_err_o),
        .dat_o      (wb_dat_o),
        .gain_o     (gain),
        .offset_o   (offset)
    );

    agc_scale i_agc_scale (
        .aclk       (aclk),
        .rst_i      (rst_i),
        .dat_i      (lane_in),
        .gain_i     (gain),
        .offset_i   (offset),
        .dat_o      (lane_out),
        .clip_add_o (clip_add)
    );

endmodule

//--- hdl/trigger_chain_x8.sv
`timescale 1ns/1ps

module trigger_chain_x8 import trigger_pkg::*; (
    input  logic                                  aclk,
    input  logic                                  rst_i,
    // configuration bus
    input  logic                                  wb_cyc_i,
    input  logic                                  wb_stb_i,
    input  logic                                  wb_we_i,
    input  logic [WB_ADR_BITS-1:0]                wb_adr_i,
    input  logic [WB_DAT_BITS-1:0]                wb_dat_i,
    output logic                                  wb_ack_o,
    output logic                                  wb_err_o,
    output logic [WB_DAT_BITS-1:0]                wb_dat_o,
    // sample streams, one word per channel per clock
    input  logic [NUM_CHAN-1:0][CHAN_IN_BITS-1:0]  dat_i,
    output logic [NUM_CHAN-1:0][CHAN_OUT_BITS-1:0] dat_o
);

    // one-hot cyc from the decoder
    logic [NUM_CHAN-1:0] chan_cyc;
    // per-channel answers back into the mux
    logic [NUM_CHAN-1:0] chan_ack;
    logic [NUM_CHAN-1:0] chan_err;
    logic [NUM_CHAN-1:0][WB_DAT_BITS-1:0] chan_dat;

    wb_chan_decode i_wb_chan_decode (
        .wb_cyc_i   (wb_cyc_i),
        .wb_adr_i   (wb_adr_i),
        .chan_ack_i (chan_ack),
        .chan_err_i (chan_err),
        .chan_dat_i (chan_dat),
        .chan_cyc_o (chan_cyc),
        .wb_ack_o   (wb_ack_o),
        .wb_err_o   (wb_err_o),
        .wb_dat_o   (wb_dat_o)
    );

    // stb, we, low address and write data go to every channel
    // only the channel with cyc acts on them
    for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
        trigger_chain i_trigger_chain (
            .aclk     (aclk),
            .rst_i    (rst_i),
            .wb_cyc_i (chan_cyc[c]),
            .wb_stb_i (wb_stb_i),
            .wb_we_i  (wb_we_i),
            .wb_adr_i (wb_adr_i[REG_ADR_BITS-1:0]),
            .wb_dat_i (wb_dat_i),
            .wb_ack_o (chan_ack[c]),
            .wb_err_o (chan_err[c]),
            .wb_dat_o (chan_dat[c]),
            .dat_i    (dat_i[c]),
            .dat_o    (dat_o[c])
        );
    end

endmodule

//--- hdl/trigger_pkg.sv
package trigger_pkg;

    // channel structure
    localparam int NUM_CHAN = 8;
    // samples per clock in one channel
    localparam int LANES = 8;

    // signed sample widths at the input and the output of the agc
    localparam int IN_BITS = 12;
    localparam int OUT_BITS = 5;
    // flat per-channel stream words, lane i at bit IN_BITS*i / OUT_BITS*i
    localparam int CHAN_IN_BITS = LANES * IN_BITS;
    localparam int CHAN_OUT_BITS = LANES * OUT_BITS;

    // wishbone bus, channel picked by adr[12:10]
    localparam int WB_ADR_BITS = 22;
    localparam int WB_DAT_BITS = 32;
    localparam int CHAN_SEL_LSB = 10;
    localparam int CHAN_SEL_BITS = 3;
    // register window inside one channel
    localparam int REG_ADR_BITS = 8;

    // gain is unsigned fixed point with 6 fraction bits, so 64 is unity
    localparam int GAIN_BITS = 10;
    localparam int GAIN_FRAC_BITS = 6;
    localparam logic [GAIN_BITS-1:0] GAIN_RESET = GAIN_BITS'(1) << GAIN_FRAC_BITS;

    // datapath widths: sample minus offset, product, product after the shift
    localparam int DIFF_BITS = IN_BITS + 1;
    localparam int PROD_BITS = DIFF_BITS + GAIN_BITS + 1;
    localparam int SCALED_BITS = PROD_BITS - GAIN_FRAC_BITS;
    // saturation limits of the output sample, -16 and 15
    localparam logic signed [OUT_BITS-1:0] OUT_MAX = {1'b0, {(OUT_BITS-1){1'b1}}};
    localparam logic signed [OUT_BITS-1:0] OUT_MIN = {1'b1, {(OUT_BITS-1){1'b0}}};

    // clip counter and the per-word tally that feeds it (0 to LANES)
    localparam int CLIP_BITS = 16;
    localparam int CLIP_ADD_BITS = $clog2(LANES + 1);

    // register byte offsets
    localparam logic [REG_ADR_BITS-1:0] REG_GAIN = REG_ADR_BITS'('h00);
    localparam logic [REG_ADR_BITS-1:0] REG_OFFSET = REG_ADR_BITS'('h04);
    localparam logic [REG_ADR_BITS-1:0] REG_CLIP = REG_ADR_BITS'('h08);

endpackage

//--- hdl/wb_chan_decode.sv
`timescale 1ns/1ps

module wb_chan_decode import trigger_pkg::*; (
    // request side from the master
    input  logic                                wb_cyc_i,
    input  logic [WB_ADR_BITS-1:0]              wb_adr_i,
    // answers from the channel targets
    input  logic [NUM_CHAN-1:0]                 chan_ack_i,
    input  logic [NUM_CHAN-1:0]                 chan_err_i,
    input  logic [NUM_CHAN-1:0][WB_DAT_BITS-1:0] chan_dat_i,
    // one-hot cycle to the channels
    output logic [NUM_CHAN-1:0]                 chan_cyc_o,
    // muxed answer back to the master
    output logic                                wb_ack_o,
    output logic                                wb_err_o,
    output logic [WB_DAT_BITS-1:0]              wb_dat_o
);

    // channel index from the address
    logic [CHAN_SEL_BITS-1:0] chan_idx;

    // only adr[12:10] matter here
    // bits 9:8 and everything above bit 12 are don't care, so windows repeat
    assign chan_idx = wb_adr_i[CHAN_SEL_LSB +: CHAN_SEL_BITS];

    // forward cyc to the one matching channel
    always_comb begin
        chan_cyc_o = '0;
        chan_cyc_o[chan_idx] = wb_cyc_i;
    end

    // answer path
    // master holds the address until ack or err, so the index is stable
    // while the selected target is answering
    // other channels never see cyc and stay quiet anyway
    // masking with cyc drops a stray answer after an aborted cycle
    assign wb_ack_o = wb_cyc_i && chan_ack_i[chan_idx];
    assign wb_err_o = wb_cyc_i && chan_err_i[chan_idx];

    // read data is only meaningful while ack is high
    assign wb_dat_o = chan_dat_i[chan_idx];

endmodule

//--- list.f
hdl/trigger_pkg.sv
hdl/wb_chan_decode.sv
hdl/agc_regs.sv
hdl/agc_scale.sv
hdl/trigger_chain.sv
hdl/trigger_chain_x8.sv
verif/trigger_chain_x8_props.sv
verif/tb_trigger_chain_x8.sv

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator, pass decided from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tb_trigger_chain_x8 \
    -f list.f

# keep going on a failing run so the log is still searched
./obj_dir/Vtb_trigger_chain_x8 > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
    echo "simulation PASS"
    exit 0
else
    echo "simulation FAIL"
    exit 1
fi

//--- verif/tb_trigger_chain_x8.sv
`timescale 1ns/1ps

module tb_trigger_chain_x8 import trigger_pkg::*; ();

    // 3 cycles per bus access, roughly 650 cycles for all tests
    localparam int MAX_CYCLES = 4000;
    localparam int BUS_WAIT = 4;
    // channel driven hard in the clip test
    localparam int CLIP_CHAN = 3;
    // bits 9:8 and 20 are outside the decode, so this aliases the same registers
    localparam logic [WB_ADR_BITS-1:0] ALIAS_BITS = 22'h10_0300;
    // output range of a 5-bit signed lane
    localparam int LANE_MAX = 2 ** (OUT_BITS - 1) - 1;
    localparam int LANE_MIN = -(2 ** (OUT_BITS - 1));

    logic aclk = 1'b0;
    logic rst_i;
    logic wb_cyc_i;
    logic wb_stb_i;
    logic wb_we_i;
    logic [WB_ADR_BITS-1:0] wb_adr_i;
    logic [WB_DAT_BITS-1:0] wb_dat_i;
    logic wb_ack_o;
    logic wb_err_o;
    logic [WB_DAT_BITS-1:0] wb_dat_o;
    logic [NUM_CHAN-1:0][CHAN_IN_BITS-1:0] dat_i;
    logic [NUM_CHAN-1:0][CHAN_OUT_BITS-1:0] dat_o;

    int seed = 32'he2d6bfda;
    int cycle_cnt = 0;
    int test_errs;
    int pass_cnt = 0;
    int fail_cnt = 0;
    string cur_test;
    // software copy of the settings and expected clip counts
    int gain_m [NUM_CHAN];
    int offset_m [NUM_CHAN];
    int clip_m [NUM_CHAN];

    always #2 aclk = ~aclk;

    trigger_chain_x8 i_trigger_chain_x8 (.*);

    // hard stop if something never answers
    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_word(input string what, input logic [WB_DAT_BITS-1:0] exp,
                              input logic [WB_DAT_BITS-1:0] act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_lane(input string what, input logic signed [OUT_BITS-1:0] exp,
                              input logic signed [OUT_BITS-1:0] act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    // (sample - offset) * gain / 64, floored, then clamped to -16..15
    function automatic logic signed [OUT_BITS-1:0] model_lane(input int sample, input int gain,
                                                              input int offset, output bit clipped);
        int scaled;
        scaled = ((sample - offset) * gain) >>> GAIN_FRAC_BITS;
        clipped = (scaled > LANE_MAX) || (scaled < LANE_MIN);
        if (scaled > LANE_MAX)
            scaled = LANE_MAX;
        else if (scaled < LANE_MIN)
            scaled = LANE_MIN;
        return OUT_BITS'(scaled);
    endfunction

    function automatic logic [IN_BITS-1:0] gen_sample(input int mode, input int c, input int idx);
        case (mode)
            // small values, unity gain leaves them alone
            0: return IN_BITS'(($random(seed) & 31) - 16);
            1: return IN_BITS'($random(seed));
            // -2..2 on the clip channel hits both edges of the clamp, zero elsewhere
            default: return (c == CLIP_CHAN) ? IN_BITS'(idx % 5 - 2) : '0;
        endcase
    endfunction

    function automatic logic [WB_ADR_BITS-1:0] reg_adr(input int c,
                                                       input logic [REG_ADR_BITS-1:0] off);
        return WB_ADR_BITS'(c << CHAN_SEL_LSB) | WB_ADR_BITS'(off);
    endfunction

    task automatic bus_cycle(input logic we, input logic [WB_ADR_BITS-1:0] adr,
                             input logic [WB_DAT_BITS-1:0] wdat,
                             output logic [WB_DAT_BITS-1:0] rdat, output logic ack,
                             output logic err);
        ack = 1'b0;
        err = 1'b0;
        rdat = '0;
        @(posedge aclk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i <= we;
        wb_adr_i <= adr;
        wb_dat_i <= wdat;
        // answer is sampled mid-cycle, data valid with ack
        for (int n = 0; n < BUS_WAIT && !ack && !err; n++) begin
            @(negedge aclk);
            ack = wb_ack_o;
            err = wb_err_o;
            rdat = wb_dat_o;
        end
        if (!ack && !err) begin
            $display("%s: no ack or err within %0d cycles at address %h", cur_test, BUS_WAIT, adr);
            test_errs++;
        end
        @(posedge aclk);
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i <= 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADR_BITS-1:0] adr, input logic [WB_DAT_BITS-1:0] wdat,
                            input logic exp_err);
        logic [WB_DAT_BITS-1:0] rdat;
        logic ack;
        logic err;
        bus_cycle(1'b1, adr, wdat, rdat, ack, err);
        check_flag("write ack", !exp_err, ack);
        check_flag("write err", exp_err, err);
    endtask

    task automatic wb_read(input logic [WB_ADR_BITS-1:0] adr, input logic exp_err,
                           output logic [WB_DAT_BITS-1:0] rdat);
        logic ack;
        logic err;
        bus_cycle(1'b0, adr, '0, rdat, ack, err);
        check_flag("read ack", !exp_err, ack);
        check_flag("read err", exp_err, err);
    endtask

    task automatic set_chan(input int c, input int gain, input int offset);
        wb_write(reg_adr(c, REG_GAIN), WB_DAT_BITS'(gain), 1'b0);
        wb_write(reg_adr(c, REG_OFFSET), WB_DAT_BITS'(offset), 1'b0);
        gain_m[c] = gain;
        offset_m[c] = offset;
    endtask

    // offset reads back sign-extended, clip count only where the model tracks it
    task automatic check_chan(input int c, input bit with_clip);
        logic [WB_DAT_BITS-1:0] rd;
        wb_read(reg_adr(c, REG_GAIN), 1'b0, rd);
        check_word($sformatf("ch%0d gain", c), WB_DAT_BITS'(gain_m[c]), rd);
        wb_read(reg_adr(c, REG_OFFSET), 1'b0, rd);
        check_word($sformatf("ch%0d offset", c), WB_DAT_BITS'(offset_m[c]), rd);
        if (with_clip) begin
            wb_read(reg_adr(c, REG_CLIP), 1'b0, rd);
            check_word($sformatf("ch%0d clip", c), WB_DAT_BITS'(clip_m[c]), rd);
        end
    endtask

    // back to back words on all channels, each one checked two cycles later
    task automatic stream_words(input int n_words, input int mode);
        logic [NUM_CHAN-1:0][CHAN_IN_BITS-1:0] word;
        logic [NUM_CHAN-1:0][CHAN_OUT_BITS-1:0] exp_word;
        logic [NUM_CHAN-1:0][CHAN_OUT_BITS-1:0] exp_q [$];
        bit clipped;
        for (int m = 0; m < n_words + 2; m++) begin
            @(posedge aclk);
            if (m < n_words) begin
                for (int c = 0; c < NUM_CHAN; c++) begin
                    for (int l = 0; l < LANES; l++) begin
                        word[c][IN_BITS*l +: IN_BITS] = gen_sample(mode, c, m * LANES + l);
                        exp_word[c][OUT_BITS*l +: OUT_BITS] = model_lane(
                            int'($signed(word[c][IN_BITS*l +: IN_BITS])),
                            gain_m[c], offset_m[c], clipped);
                        if (clipped)
                            clip_m[c]++;
                    end
                end
                exp_q.push_back(exp_word);
                dat_i <= word;
            end else begin
                dat_i <= '0;
            end
            // word m-2 sits at dat_o now
            @(negedge aclk);
            if (m >= 2) begin
                exp_word = exp_q.pop_front();
                for (int c = 0; c < NUM_CHAN; c++) begin
                    for (int l = 0; l < LANES; l++) begin
                        check_lane($sformatf("word %0d ch%0d lane%0d", m - 2, c, l),
                                   exp_word[c][OUT_BITS*l +: OUT_BITS],
                                   dat_o[c][OUT_BITS*l +: OUT_BITS]);
                    end
                end
            end
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            pass_cnt++;
            $display("%s: ok", cur_test);
        end else begin
            fail_cnt++;
            $display("%s: %0d errors", cur_test, test_errs);
        end
    endtask

    task automatic test_reset_defaults();
        begin_test("reset_defaults");
        for (int c = 0; c < NUM_CHAN; c++)
            check_chan(c, 1'b1);
        // in-range samples first, then full range that mostly clamps
        stream_words(20, 0);
        stream_words(20, 1);
        end_test();
    endtask

    task automatic test_isolation();
        logic [WB_DAT_BITS-1:0] rd;
        begin_test("isolation");
        for (int c = 0; c < NUM_CHAN; c++)
            set_chan(c, 10 + 37 * c, 100 * c - 350);
        for (int c = 0; c < NUM_CHAN; c++)
            check_chan(c, 1'b0);
        // ch5 written through its alias, the rest must keep their values
        wb_write(reg_adr(5, REG_GAIN) | ALIAS_BITS, 32'd777, 1'b0);
        gain_m[5] = 777;
        for (int c = 0; c < NUM_CHAN; c++)
            check_chan(c, 1'b0);
        wb_read(reg_adr(5, REG_GAIN) | ALIAS_BITS, 1'b0, rd);
        check_word("ch5 gain via alias", 32'd777, rd);
        end_test();
    endtask

    task automatic test_scaling();
        begin_test("scaling");
        for (int c = 0; c < NUM_CHAN; c++)
            set_chan(c, $random(seed) & 1023, ($random(seed) & 4095) - 2048);
        stream_words(100, 1);
        end_test();
    endtask

    task automatic test_clip_count();
        logic [WB_DAT_BITS-1:0] rd;
        begin_test("clip_count");
        // unity and zero input everywhere, so counters stay at 0 after the clear
        for (int c = 0; c < NUM_CHAN; c++)
            set_chan(c, 64, 0);
        for (int c = 0; c < NUM_CHAN; c++) begin
            wb_write(reg_adr(c, REG_CLIP), '0, 1'b0);
            clip_m[c] = 0;
        end
        set_chan(CLIP_CHAN, 1023, 0);
        stream_words(24, 2);
        for (int c = 0; c < NUM_CHAN; c++)
            check_chan(c, 1'b1);
        wb_write(reg_adr(CLIP_CHAN, REG_CLIP), 32'h1234, 1'b0);
        clip_m[CLIP_CHAN] = 0;
        wb_read(reg_adr(CLIP_CHAN, REG_CLIP), 1'b0, rd);
        check_word("clip after clear", '0, rd);
        end_test();
    endtask

    task automatic test_errors();
        logic [WB_DAT_BITS-1:0] rd;
        begin_test("errors");
        // nonzero clip count first, so a stray clear would show up
        stream_words(4, 2);
        // write data differs from the gain of 1023 held on this channel
        wb_write(reg_adr(CLIP_CHAN, 8'h0C), 32'h155, 1'b1);
        wb_write(reg_adr(CLIP_CHAN, 8'h40), 32'h2AA, 1'b1);
        wb_read(reg_adr(CLIP_CHAN, 8'h0C), 1'b1, rd);
        wb_read(reg_adr(CLIP_CHAN, 8'h40), 1'b1, rd);
        check_chan(CLIP_CHAN, 1'b1);
        end_test();
    endtask

    initial begin
        rst_i <= 1'b1;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i <= 1'b0;
        wb_adr_i <= '0;
        wb_dat_i <= '0;
        dat_i <= '0;
        for (int c = 0; c < NUM_CHAN; c++) begin
            gain_m[c] = 64;
            offset_m[c] = 0;
            clip_m[c] = 0;
        end
        repeat (16) @(posedge aclk);
        rst_i <= 1'b0;
        test_reset_defaults();
        test_isolation();
        test_scaling();
        test_clip_count();
        test_errors();
        $display("tests ok: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verif/trigger_chain_x8_props.sv
`timescale 1ns/1ps

module trigger_chain_x8_props (
    input logic aclk,
    input logic rst_i,
    input logic wb_cyc_i,
    input logic wb_stb_i,
    input logic wb_ack_i,
    input logic wb_err_i
);

    // target answers this cycle
    logic answer;

    assign answer = wb_ack_i || wb_err_i;

    // one kind of answer at a time
    a_ack_err_excl: assert property (@(posedge aclk) disable iff (rst_i)
        !(wb_ack_i && wb_err_i))
        else $error("wishbone ack and err high together");

    // answer only after a request in the cycle before
    a_answer_after_req: assert property (@(posedge aclk) disable iff (rst_i)
        answer |-> $past(wb_cyc_i && wb_stb_i))
        else $error("wishbone answer without a request");

    // single-cycle answers
    a_no_back_to_back: assert property (@(posedge aclk) disable iff (rst_i)
        answer |=> !answer)
        else $error("wishbone answer in two consecutive cycles");

    // bus quiet right out of reset
    a_quiet_after_reset: assert property (@(posedge aclk)
        $past(rst_i) |-> !answer)
        else $error("wishbone answer in the cycle after reset");

endmodule

bind trigger_chain_x8 trigger_chain_x8_props i_trigger_chain_x8_props (
    .aclk     (aclk),
    .rst_i    (rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_ack_i (wb_ack_o),
    .wb_err_i (wb_err_o)
);
